//--- verilog.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_array_if.sv
rtl/dp_ram.sv
rtl/cache.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
test/mem_model.sv
test/tb_cache_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/1ps --top-module tb_cache_top -f verilog.f -o sim_tb \
    > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "result: fail"; exit 1; } || { echo "result: pass"; exit 0; }

//--- test/tb_cache_top.sv
// one blocking access at a time, the shadow memory must start from the same xorshift seed as mem_model
`include "cache_params.svh"

module tb_cache_top;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    localparam int TIMEOUT      = 200;
    localparam int MEM_WORDS    = 16384;
    localparam int MAX_ENTRIES  = 32;
    localparam int RAND_ENTRIES = 8;

    typedef struct packed {
        logic   we;
        addr_t  addr;
        word_t  wdata;
        int     stall;
        word_t  exp;
    } entry_t;

    logic   clk;
    logic   n_rst;
    logic   req_valid;
    logic   req_ready;
    logic   req_we;
    addr_t  req_addr;
    word_t  req_wdata;
    logic   rsp_valid;
    logic   rsp_ready;
    word_t  rsp_rdata;
    logic   mem_req_valid;
    logic   mem_req_ready;
    logic   mem_req_we;
    addr_t  mem_req_addr;
    line_t  mem_req_wdata;
    logic   mem_rsp_valid;
    logic   mem_rsp_ready;
    line_t  mem_rsp_rdata;
    int     wb_count;
    addr_t  last_wb_addr;

    entry_t stim [MAX_ENTRIES];
    int     num_entries;
    word_t  shadow [MEM_WORDS];
    logic   sh_valid [`CACHE_LINE_COUNT];
    logic   sh_dirty [`CACHE_LINE_COUNT];
    tag_t   sh_tag [`CACHE_LINE_COUNT];
    int     errors;
    int     timeouts;
    int     exp_wb;
    addr_t  exp_last_wb;

    cache_top cache_top_inst (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_req_valid     (req_valid),
        .o_req_ready     (req_ready),
        .i_req_we        (req_we),
        .i_req_addr      (req_addr),
        .i_req_wdata     (req_wdata),
        .o_rsp_valid     (rsp_valid),
        .i_rsp_ready     (rsp_ready),
        .o_rsp_rdata     (rsp_rdata),
        .o_mem_req_valid (mem_req_valid),
        .i_mem_req_ready (mem_req_ready),
        .o_mem_req_we    (mem_req_we),
        .o_mem_req_addr  (mem_req_addr),
        .o_mem_req_wdata (mem_req_wdata),
        .i_mem_rsp_valid (mem_rsp_valid),
        .o_mem_rsp_ready (mem_rsp_ready),
        .i_mem_rsp_rdata (mem_rsp_rdata)
    );

    mem_model mem_inst (
        .clk            (clk),
        .i_req_valid    (mem_req_valid),
        .o_req_ready    (mem_req_ready),
        .i_req_we       (mem_req_we),
        .i_req_addr     (mem_req_addr),
        .i_req_wdata    (mem_req_wdata),
        .o_rsp_valid    (mem_rsp_valid),
        .i_rsp_ready    (mem_rsp_ready),
        .o_rsp_rdata    (mem_rsp_rdata),
        .o_wb_count     (wb_count),
        .o_last_wb_addr (last_wb_addr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("Error: %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string name, input string what);
        timeouts++;
        $display("Timeout in %s: %s", name, what);
    endtask

    task automatic add_entry(input logic we, input addr_t addr, input word_t wdata, input int stall);
        stim[num_entries] = '{we, addr, wdata, stall, '0};
        num_entries++;
    endtask

    // applies the direct-mapped, write-allocate rules to the shadow state before the access runs
    task automatic predict(input int i, output logic hit);
        tag_t    tg;
        index_t  idx;
        offset_t off;
        int      w;
        {tg, idx, off} = stim[i].addr;
        w = stim[i].addr / 4;
        hit = sh_valid[idx] && (sh_tag[idx] == tg);
        if (!hit) begin
            if (sh_valid[idx] && sh_dirty[idx]) begin
                exp_wb++;
                exp_last_wb = {sh_tag[idx], idx, offset_t'(0)};
            end
            sh_valid[idx] = 1'b1;
            sh_tag[idx]   = tg;
            sh_dirty[idx] = 1'b0;
        end
        if (stim[i].we) begin
            shadow[w]     = stim[i].wdata;
            sh_dirty[idx] = 1'b1;
        end else begin
            stim[i].exp = shadow[w];
        end
    endtask

    task automatic run_entry(input int i);
        string  name;
        logic   hit;
        int     lat;
        word_t  held;
        name = $sformatf("entry %0d addr %h", i, stim[i].addr);
        // between accesses the controller sits in IDLE with every handshake output at rest
        check_flag({name, " idle request ready"}, 1'b1, req_ready);
        check_flag({name, " idle response valid"}, 1'b0, rsp_valid);
        check_flag({name, " idle memory request valid"}, 1'b0, mem_req_valid);
        check_flag({name, " idle memory response ready"}, 1'b0, mem_rsp_ready);
        predict(i, hit);
        @(negedge clk);
        req_valid = 1'b1;
        req_we    = stim[i].we;
        req_addr  = stim[i].addr;
        req_wdata = stim[i].wdata;
        lat = 0;
        while (!req_ready && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
        end
        if (!req_ready) begin
            report_timeout(name, "the cache never accepted the request");
            return;
        end
        // acceptance edge
        @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        lat = 1;
        while (!rsp_valid && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
        end
        if (!rsp_valid) begin
            report_timeout(name, "no response arrived");
            return;
        end
        if (hit) begin
            check_count({name, " hit latency"}, 2, lat);
        end
        held = rsp_rdata;
        for (int s = 0; s < stim[i].stall; s++) begin
            @(negedge clk);
            if (!rsp_valid || req_ready) begin
                errors++;
                $display("%s: response valid dropped or request ready rose during the stall", name);
            end
            check_word({name, " held data"}, held, rsp_rdata);
        end
        if (!stim[i].we) begin
            check_word({name, " read data"}, stim[i].exp, rsp_rdata);
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        check_count({name, " write-back count"}, exp_wb, wb_count);
        if (exp_wb > 0) begin
            check_addr({name, " last write-back address"}, exp_last_wb, last_wb_addr);
        end
    endtask

    // index 0 and 3 lines get dirtied and then evicted, index 15 covers the top of memory
    task automatic load_directed();
        add_entry(1'b0, 16'h0104, '0, 0);
        add_entry(1'b0, 16'h0108, '0, 0);
        add_entry(1'b1, 16'h0108, 32'hcafe0001, 0);
        add_entry(1'b0, 16'h0108, '0, 3);
        add_entry(1'b1, 16'h0234, 32'h12345678, 0);
        add_entry(1'b0, 16'h0234, '0, 0);
        add_entry(1'b0, 16'h0500, '0, 0);
        add_entry(1'b0, 16'h0108, '0, 1);
        add_entry(1'b0, 16'h0630, '0, 0);
        add_entry(1'b0, 16'h0234, '0, 2);
        add_entry(1'b1, 16'hfffc, 32'ha5a55a5a, 1);
        add_entry(1'b0, 16'h00fc, '0, 0);
        add_entry(1'b0, 16'h00f0, '0, 0);
    endtask

    initial begin
        word_t x;
        n_rst       = 1'b0;
        req_valid   = 1'b0;
        req_we      = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        rsp_ready   = 1'b0;
        errors      = 0;
        timeouts    = 0;
        exp_wb      = 0;
        exp_last_wb = '0;
        num_entries = 0;
        x = 32'h30807d77;
        for (int k = 0; k < MEM_WORDS; k++) begin
            x = xorshift(x);
            shadow[k] = x;
        end
        for (int n = 0; n < `CACHE_LINE_COUNT; n++) begin
            sh_valid[n] = 1'b0;
            sh_dirty[n] = 1'b0;
            sh_tag[n]   = '0;
        end
        load_directed();
        // the random tail keeps tags small so that lines keep colliding
        for (int r = 0; r < RAND_ENTRIES; r++) begin
            x = xorshift(x);
            add_entry(x[31], {6'h00, x[9:2], 2'b00}, x ^ 32'h5a5a5a5a, int'(x[20:19]));
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        for (int i = 0; i < num_entries && timeouts == 0; i++) begin
            run_entry(i);
        end
        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- test/mem_model.sv
// 64 KB line-wide backing memory, line-aligned addresses assumed, every write counts as a write-back
module mem_model (
    input  logic              clk,
    input  logic              i_req_valid,
    output logic              o_req_ready,
    input  logic              i_req_we,
    input  cache_pkg::addr_t  i_req_addr,
    input  cache_pkg::line_t  i_req_wdata,
    output logic              o_rsp_valid,
    input  logic              i_rsp_ready,
    output cache_pkg::line_t  o_rsp_rdata,
    output int                o_wb_count,
    output cache_pkg::addr_t  o_last_wb_addr
);
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    localparam int WORDS     = 16384;
    localparam int RSP_DELAY = 3;

    word_t  mem [WORDS];
    logic   pending;
    int     wait_cnt;
    addr_t  rd_addr;
    logic   req_fire;
    logic   rsp_fire;
    logic   fire_we;
    addr_t  fire_addr;
    line_t  fire_data;

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        word_t x;
        x = 32'h30807d77;
        for (int k = 0; k < WORDS; k++) begin
            x = xorshift(x);
            mem[k] = x;
        end
        pending        = 1'b0;
        wait_cnt       = 0;
        rd_addr        = '0;
        req_fire       = 1'b0;
        rsp_fire       = 1'b0;
        fire_we        = 1'b0;
        fire_addr      = '0;
        fire_data      = '0;
        o_req_ready    = 1'b1;
        o_rsp_valid    = 1'b0;
        o_rsp_rdata    = '0;
        o_wb_count     = 0;
        o_last_wb_addr = '0;
        forever begin
            @(negedge clk);
            // a transfer flagged at the last falling edge took place on the rising edge since
            if (rsp_fire) begin
                pending = 1'b0;
            end else if (pending && wait_cnt > 0) begin
                wait_cnt--;
            end
            if (req_fire) begin
                if (fire_we) begin
                    for (int w = 0; w < 4; w++) begin
                        mem[{fire_addr[15:4], 2'(w)}] = fire_data[w*32 +: 32];
                    end
                    o_wb_count++;
                    o_last_wb_addr = fire_addr;
                end else begin
                    pending  = 1'b1;
                    wait_cnt = RSP_DELAY;
                    rd_addr  = fire_addr;
                end
            end
            o_req_ready = !pending;
            o_rsp_valid = pending && (wait_cnt == 0);
            for (int w = 0; w < 4; w++) begin
                o_rsp_rdata[w*32 +: 32] = mem[{rd_addr[15:4], 2'(w)}];
            end
            // the cache's side only changes on the rising edge, so this is what it will present
            req_fire  = o_req_ready && i_req_valid;
            rsp_fire  = o_rsp_valid && i_rsp_ready;
            fire_we   = i_req_we;
            fire_addr = i_req_addr;
            fire_data = i_req_wdata;
        end
    end

endmodule

//--- rtl/cache_top.sv
// one blocking processor port and one line-wide memory port, the backing memory lives outside
`include "cache_params.svh"

module cache_top (
    input  logic               clk,
    input  logic               n_rst,

    input  logic               i_req_valid,
    output logic               o_req_ready,
    input  logic               i_req_we,
    input  cache_pkg::addr_t   i_req_addr,
    input  cache_pkg::word_t   i_req_wdata,
    output logic               o_rsp_valid,
    input  logic               i_rsp_ready,
    output cache_pkg::word_t   o_rsp_rdata,

    output logic               o_mem_req_valid,
    input  logic               i_mem_req_ready,
    output logic               o_mem_req_we,
    output cache_pkg::addr_t   o_mem_req_addr,
    output cache_pkg::line_t   o_mem_req_wdata,
    input  logic               i_mem_rsp_valid,
    output logic               o_mem_rsp_ready,
    input  cache_pkg::line_t   i_mem_rsp_rdata
);

    cache_array_if arr_if ();

    cache_ctrl ctrl_inst (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_we        (i_req_we),
        .i_req_addr      (i_req_addr),
        .i_req_wdata     (i_req_wdata),
        .o_rsp_valid     (o_rsp_valid),
        .i_rsp_ready     (i_rsp_ready),
        .o_rsp_rdata     (o_rsp_rdata),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_req_we    (o_mem_req_we),
        .o_mem_req_addr  (o_mem_req_addr),
        .o_mem_req_wdata (o_mem_req_wdata),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .o_mem_rsp_ready (o_mem_rsp_ready),
        .i_mem_rsp_rdata (i_mem_rsp_rdata),
        .arr             (arr_if.ctrl)
    );

    cache #(
        .DATA_WIDTH      (`CACHE_WORD_WIDTH),
        .ADDR_WIDTH      (`CACHE_ADDR_WIDTH),
        .CACHE_SIZE      (`CACHE_SIZE),
        .CACHE_LINE_SIZE (`CACHE_LINE_SIZE)
    ) cache_inst (
        .clk   (clk),
        .n_rst (n_rst),
        .arr   (arr_if.array)
    );

endmodule

//--- rtl/cache_ctrl.sv
// blocking controller with one request in flight, word-aligned addresses and no byte enables
module cache_ctrl (
    input  logic               clk,
    input  logic               n_rst,

    // processor port
    input  logic               i_req_valid,
    output logic               o_req_ready,
    input  logic               i_req_we,
    input  cache_pkg::addr_t   i_req_addr,
    input  cache_pkg::word_t   i_req_wdata,
    output logic               o_rsp_valid,
    input  logic               i_rsp_ready,
    output cache_pkg::word_t   o_rsp_rdata,

    // backing memory port, one full line per transfer
    output logic               o_mem_req_valid,
    input  logic               i_mem_req_ready,
    output logic               o_mem_req_we,
    output cache_pkg::addr_t   o_mem_req_addr,
    output cache_pkg::line_t   o_mem_req_wdata,
    input  logic               i_mem_rsp_valid,
    output logic               o_mem_rsp_ready,
    input  cache_pkg::line_t   i_mem_rsp_rdata,

    cache_array_if.ctrl        arr
);
    import cache_pkg::*;

    ctrl_state_t  state_q;
    ctrl_state_t  state_d;

    logic         req_we_q;
    addr_t        req_addr_q;
    word_t        req_wdata_q;
    word_t        rsp_rdata_q;
    addr_t        victim_addr_q;
    line_t        victim_line_q;

    tag_t         req_tag;
    index_t       req_index;
    offset_t      req_offset;

    logic         accept;
    logic         lookup_hit;
    logic         lookup_evict;

    assign {req_tag, req_index, req_offset} = req_addr_q;

    assign accept       = (state_q == IDLE) && i_req_valid;
    assign lookup_hit   = (state_q == LOOKUP) && arr.hit;
    assign lookup_evict = (state_q == LOOKUP) && !arr.hit && arr.dirty;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_req_valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (arr.hit) begin
                    state_d = RESPOND;
                end else if (arr.dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = FILL_REQ;
                end
            end
            WRITEBACK: begin
                if (i_mem_req_ready) begin
                    state_d = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (i_mem_req_ready) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                // after the fill the second lookup is guaranteed to hit
                if (i_mem_rsp_valid) begin
                    state_d = LOOKUP;
                end
            end
            RESPOND: begin
                if (i_rsp_ready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request and eviction payload, each held until the next access overwrites it
    always_ff @(posedge clk) begin
        if (accept) begin
            req_we_q    <= i_req_we;
            req_addr_q  <= i_req_addr;
            req_wdata_q <= i_req_wdata;
        end
        if (lookup_hit) begin
            rsp_rdata_q <= arr.rdata;
        end
        if (lookup_evict) begin
            victim_addr_q <= {arr.victim_tag, req_index, offset_t'(0)};
            victim_line_q <= arr.vdata;
        end
    end

    assign o_req_ready     = (state_q == IDLE);
    assign o_rsp_valid     = (state_q == RESPOND);
    assign o_rsp_rdata     = rsp_rdata_q;

    // the line address and data stay fixed for the whole request phase
    assign o_mem_req_valid = (state_q == WRITEBACK) || (state_q == FILL_REQ);
    assign o_mem_req_we    = (state_q == WRITEBACK);
    assign o_mem_req_addr  = (state_q == WRITEBACK) ? victim_addr_q
                                                    : {req_tag, req_index, offset_t'(0)};
    assign o_mem_req_wdata = victim_line_q;
    assign o_mem_rsp_ready = (state_q == FILL_WAIT);

    // storage is addressed from the latched request throughout the access
    assign arr.re     = (state_q == LOOKUP);
    assign arr.we     = (state_q == LOOKUP) && req_we_q;
    assign arr.fe     = (state_q == FILL_WAIT) && i_mem_rsp_valid;
    // every fill installs a valid line
    assign arr.valid  = 1'b1;
    assign arr.offset = req_offset;
    assign arr.index  = req_index;
    assign arr.tag    = req_tag;
    assign arr.fdata  = i_mem_rsp_rdata;
    assign arr.wdata  = req_wdata_q;

endmodule

//--- rtl/cache.sv
// direct-mapped storage, word-aligned offsets assumed and field widths must match cache_array_if
module cache #(
    parameter int DATA_WIDTH      = 32,
    parameter int ADDR_WIDTH      = 16,
    parameter int CACHE_SIZE      = 256,
    parameter int CACHE_LINE_SIZE = 16
) (
    input  logic          clk,
    input  logic          n_rst,
    cache_array_if.array  arr
);

    localparam int WORD_BYTES   = DATA_WIDTH / 8;
    localparam int LINE_COUNT   = CACHE_SIZE / CACHE_LINE_SIZE;
    localparam int OFFSET_WIDTH = $clog2(CACHE_LINE_SIZE);
    localparam int INDEX_WIDTH  = $clog2(LINE_COUNT);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WIDTH   = CACHE_LINE_SIZE * 8;

    logic [LINE_COUNT-1:0]    valid_bits;
    logic [LINE_COUNT-1:0]    dirty_bits;

    logic [OFFSET_WIDTH-1:0]  offset;
    logic [INDEX_WIDTH-1:0]   index;
    logic                     line_valid;
    logic                     line_hit;
    logic                     write_hit;
    logic                     ram_re;

    logic [TAG_WIDTH-1:0]     tag_rd;
    logic [LINE_WIDTH-1:0]    line_rd;
    logic [LINE_WIDTH-1:0]    line_wr;
    logic [DATA_WIDTH-1:0]    word_rd;

    assign offset     = arr.offset;
    assign index      = arr.index;
    assign line_valid = valid_bits[index];
    assign line_hit   = line_valid && (tag_rd == arr.tag);

    // a write only lands in the line when the tag matches
    assign write_hit  = arr.we && line_hit;

    // the old line is read for every access so that a merge or eviction can use it
    assign ram_re     = arr.re || arr.we || arr.fe;

    assign arr.hit        = line_hit;
    assign arr.dirty      = line_valid && dirty_bits[index];
    assign arr.victim_tag = tag_rd;
    assign arr.vdata      = line_rd;
    assign arr.rdata      = word_rd;

    // byte b of the word comes from byte lane offset+b of the line
    always_comb begin
        word_rd = '0;
        for (int b = 0; b < WORD_BYTES; b++) begin
            for (int k = 0; k < CACHE_LINE_SIZE; k++) begin
                if (k == int'(offset) + b) begin
                    word_rd[b*8 +: 8] = line_rd[k*8 +: 8];
                end
            end
        end
    end

    // a fill replaces the whole line, a write hit patches one word into the old one
    always_comb begin
        line_wr = line_rd;
        if (arr.fe) begin
            line_wr = arr.fdata;
        end else if (write_hit) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                for (int k = 0; k < CACHE_LINE_SIZE; k++) begin
                    if (k == int'(offset) + b) begin
                        line_wr[k*8 +: 8] = arr.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    // a freshly filled line is clean, a write hit marks it dirty
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (arr.fe) begin
            valid_bits[index] <= arr.valid;
            dirty_bits[index] <= 1'b0;
        end else if (write_hit) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    dp_ram #(
        .DATA_WIDTH (LINE_WIDTH),
        .RAM_DEPTH  (LINE_COUNT)
    ) data_ram (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_ram_rd_en   (ram_re),
        .i_ram_rd_addr (index),
        .o_ram_rd_data (line_rd),
        .i_ram_wr_en   (arr.fe || write_hit),
        .i_ram_wr_addr (index),
        .i_ram_wr_data (line_wr)
    );

    // tags only change when a new line is brought in
    dp_ram #(
        .DATA_WIDTH (TAG_WIDTH),
        .RAM_DEPTH  (LINE_COUNT)
    ) tag_ram (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_ram_rd_en   (ram_re),
        .i_ram_rd_addr (index),
        .o_ram_rd_data (tag_rd),
        .i_ram_wr_en   (arr.fe),
        .i_ram_wr_addr (index),
        .i_ram_wr_data (arr.tag)
    );

endmodule

//--- rtl/dp_ram.sv
// contents are undefined after power-up, so the owner must track which entries are valid
module dp_ram #(
    parameter int DATA_WIDTH = 32,
    parameter int RAM_DEPTH  = 16
) (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          i_ram_rd_en,
    input  logic [$clog2(RAM_DEPTH)-1:0]  i_ram_rd_addr,
    output logic [DATA_WIDTH-1:0]         o_ram_rd_data,
    input  logic                          i_ram_wr_en,
    input  logic [$clog2(RAM_DEPTH)-1:0]  i_ram_wr_addr,
    input  logic [DATA_WIDTH-1:0]         i_ram_wr_data
);

    logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];

    // read port is a plain mux, so data shows up in the same cycle as the address
    assign o_ram_rd_data = i_ram_rd_en ? mem[i_ram_rd_addr] : '0;

    // writes are ignored while reset is held
    always_ff @(posedge clk) begin
        if (i_ram_wr_en && n_rst) begin
            mem[i_ram_wr_addr] <= i_ram_wr_data;
        end
    end

endmodule

//--- rtl/cache_array_if.sv
// storage answers combinationally on this bundle and updates only on the clock edge
interface cache_array_if;
    import cache_pkg::*;

    // request side, driven by the controller
    logic       re;
    logic       we;
    logic       fe;
    logic       valid;
    offset_t    offset;
    index_t     index;
    tag_t       tag;
    line_t      fdata;
    word_t      wdata;

    // lookup results, driven by the storage
    logic       dirty;
    logic       hit;
    tag_t       victim_tag;
    line_t      vdata;
    word_t      rdata;

    modport ctrl (
        output re, we, fe, valid, offset, index, tag, fdata, wdata,
        input  dirty, hit, victim_tag, vdata, rdata
    );

    modport array (
        input  re, we, fe, valid, offset, index, tag, fdata, wdata,
        output dirty, hit, victim_tag, vdata, rdata
    );

endinterface

//--- rtl/cache_pkg.sv
// widths follow cache_params.svh, and a byte address splits as tag, index, offset from the top
`include "cache_params.svh"

package cache_pkg;

    // one processor word and one byte address
    typedef logic [`CACHE_WORD_WIDTH-1:0]   word_t;
    typedef logic [`CACHE_ADDR_WIDTH-1:0]   addr_t;

    // address fields
    typedef logic [`CACHE_TAG_WIDTH-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_WIDTH-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_WIDTH-1:0] offset_t;

    // a full cache line, also the width of the memory port
    typedef logic [`CACHE_LINE_WIDTH-1:0]   line_t;

    // controller states
    // the fill returns to LOOKUP so that the access completes through the hit path
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT,
        RESPOND
    } ctrl_state_t;

endpackage

//--- rtl/cache_params.svh
// cache geometry for a power-of-two direct-mapped cache with word-aligned accesses only
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// processor side
`define CACHE_WORD_WIDTH    32
`define CACHE_ADDR_WIDTH    16

// cache capacity and line size in bytes
`define CACHE_SIZE          256
`define CACHE_LINE_SIZE     16

// derived sizes, all of which follow from the four values above
`define CACHE_LINE_COUNT    (`CACHE_SIZE / `CACHE_LINE_SIZE)
`define CACHE_OFFSET_WIDTH  ($clog2(`CACHE_LINE_SIZE))
`define CACHE_INDEX_WIDTH   ($clog2(`CACHE_LINE_COUNT))
`define CACHE_TAG_WIDTH     (`CACHE_ADDR_WIDTH - `CACHE_INDEX_WIDTH - `CACHE_OFFSET_WIDTH)
`define CACHE_LINE_WIDTH    (`CACHE_LINE_SIZE * 8)

`endif
